//--- verilog.f
design/vendPkg.sv
design/itemStatus.sv
design/vendController.sv
design/segmentEncoder.sv
design/displayScanner.sv
design/vendingMachine.sv
sim/clockGen.sv
sim/vendingMachineTb.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
set -e
verilator --binary --timing --timescale 1ns/1ps --top-module vendingMachineTb \
    -f verilog.f -o simv
out=$(./obj_dir/simv)
echo "$out"
echo "$out" | grep -qx "TEST PASS"

//--- sim/vendingMachineTb.sv
`timescale 1ns/1ps
`default_nettype none

module vendingMachineTb import vendPkg::*; ();

    localparam centsT PRICE_TABLE [NUM_ITEMS] = '{
        9'd100, 9'd0, 9'd125, 9'd175, 9'd225, 9'd250, 9'd100, 9'd325, 9'd375
    };
    localparam int COIN_VALUE [6] = '{5, 10, 25, 50, 100, 500};   // cents, by coinT code
    localparam int LIMIT          = 500;                           // credit ceiling
    localparam int SCAN_TIMEOUT   = 40;    // cycles for one anode to come up

    logic                 A1;
    logic                 A2;
    logic                 selPress;
    itemIdxT              selItem;
    logic                 coinIn;
    coinT                 coinType;
    logic                 cancel;
    logic                 showRefund;
    logic [NUM_ITEMS-1:0] availLed;
    logic [NUM_ITEMS-1:0] soldOutLed;
    logic [NUM_ITEMS-1:0] dispensedLed;
    logic [3:0]           anodes;
    segT                  segments;

    int                   mCredit = 0;     // model of the controller
    int                   mRefused = 0;
    int                   mDisp = 0;       // negative means a shortfall
    logic [NUM_ITEMS-1:0] mDispensed = '0;
    int                   errorCount = 0;
    int                   checkCount = 0;
    int                   seed = 42;
    logic                 hangSeen = 1'b0;
    string                hangReason;

    clockGen clockGenInst (.clk(A1), .rst(A2));

    vendingMachine #(.PRICES(PRICE_TABLE), .MAX_CREDIT(9'(LIMIT)), .SCAN_BITS(3)) UUT (.*);

    always @(posedge hangSeen) begin
        $display("timeout: %s", hangReason);
        $display("TEST FAIL");
        $finish;
    end

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("FAIL @%0t: %s got %h expected %h", $time, what, actual, expected);
        end
    endtask

    // bytes {digit3, digit2, digit1, digit0}, minus in digit 3 when negative
    function automatic logic [31:0] expectedDigits(input int num);
        int  mag;
        segT top;
        mag = (num < 0) ? -num : num;
        top = (num < 0) ? SEG_MINUS : SEG_DIGIT[4'((mag / 1000) % 10)];
        return {top, SEG_DIGIT[4'((mag / 100) % 10)] & 8'hFE,
                SEG_DIGIT[4'((mag / 10) % 10)], SEG_DIGIT[4'(mag % 10)]};
    endfunction

    // one pulse set, served in priority order
    function automatic void modelStep(input bit sel, input int item, input bit coin,
                                      input coinT c, input bit can, input bit show);
        int price;
        int value;
        price = int'(PRICE_TABLE[4'(item)]);
        value = COIN_VALUE[c];
        if (sel) begin
            if (mCredit == 0) begin
                mDisp = price;                 // price check
            end else if (price != 0 && mCredit >= price) begin
                mDisp      = mCredit - price;
                mCredit    = 0;
                mDispensed = 9'b1 << item;
            end else if (price != 0) begin
                mDisp = mCredit - price;
            end
        end else if (coin) begin
            if (mCredit + value <= LIMIT) begin
                mCredit = mCredit + value;
                mDisp   = mCredit;
            end else begin
                mRefused = (mRefused + value > 9999) ? 9999 : mRefused + value;
            end
        end else if (can) begin
            mCredit    = 0;
            mRefused   = 0;
            mDispensed = '0;
            mDisp      = 0;
        end else if (show) begin
            mDisp = mRefused;
        end
    endfunction

    // byte under each anode, digit 0 first
    task automatic captureDigits(output logic [31:0] seen);
        logic [3:0] want;
        int         waitCount;
        seen = '0;
        for (int k = 0; k < 4 && !hangSeen; k++) begin
            want      = ~(4'b0001 << k);
            waitCount = 0;
            while (anodes !== want && waitCount < SCAN_TIMEOUT) begin
                @(negedge A1);
                waitCount++;
            end
            if (anodes !== want) begin
                hangReason = $sformatf("anode pattern %b for digit %0d never came up", want, k);
                hangSeen   = 1'b1;
            end
            seen[8*k +: 8] = segments;
        end
    endtask

    task automatic checkOutputs(input string label);
        logic [NUM_ITEMS-1:0] availExp;
        logic [NUM_ITEMS-1:0] soldExp;
        logic [31:0]          seen;
        int                   price;
        for (int i = 0; i < NUM_ITEMS; i++) begin
            price       = int'(PRICE_TABLE[i]);
            soldExp[i]  = (price == 0);                       // empty slot
            availExp[i] = (price != 0) && (mCredit >= price);
        end
        @(negedge A1);
        checkValue(32'(availLed), 32'(availExp), {label, ": availLed"});
        checkValue(32'(soldOutLed), 32'(soldExp), {label, ": soldOutLed"});
        checkValue(32'(dispensedLed), 32'(mDispensed), {label, ": dispensedLed"});
        captureDigits(seen);
        if (!hangSeen) begin
            checkValue(seen, expectedDigits(mDisp), {label, ": digits"});
        end
    endtask

    task automatic applyPulse(input bit sel, input int item, input bit coin, input coinT c,
                              input bit can, input bit show, input string label);
        @(posedge A1);
        selPress   <= sel;
        selItem    <= itemIdxT'(item);
        coinIn     <= coin;
        coinType   <= c;
        cancel     <= can;
        showRefund <= show;
        @(posedge A1);
        selPress   <= 1'b0;
        coinIn     <= 1'b0;
        cancel     <= 1'b0;
        showRefund <= 1'b0;
        modelStep(sel, item, coin, c, can, show);
        repeat (3) @(posedge A1);   // controller, then encoder
        checkOutputs(label);
    endtask

    initial begin
        int r;
        int pick;
        int waitCount;
        selPress   = 1'b0;
        selItem    = '0;
        coinIn     = 1'b0;
        coinType   = NICKEL;
        cancel     = 1'b0;
        showRefund = 1'b0;
        waitCount  = 0;
        while (A2 !== 1'b0 && waitCount < 20) begin
            @(negedge A1);
            waitCount++;
        end
        if (A2 !== 1'b0) begin
            hangReason = "reset was never released";
            hangSeen   = 1'b1;
        end
        checkOutputs("after reset");
        for (int i = 0; i < NUM_ITEMS; i++) begin
            applyPulse(1'b1, i, 1'b0, NICKEL, 1'b0, 1'b0, "price check");
        end
        applyPulse(1'b0, 0, 1'b1, DOLLAR, 1'b0, 1'b0, "coin dollar");
        applyPulse(1'b0, 0, 1'b1, QUARTER, 1'b0, 1'b0, "coin quarter");
        applyPulse(1'b0, 0, 1'b1, FIVE, 1'b0, 1'b0, "coin over limit");
        applyPulse(1'b0, 0, 1'b0, NICKEL, 1'b0, 1'b1, "show refused");
        applyPulse(1'b1, 0, 1'b0, NICKEL, 1'b0, 1'b0, "vend item 0");
        applyPulse(1'b0, 0, 1'b1, DOLLAR, 1'b0, 1'b0, "coin after vend");
        applyPulse(1'b1, 3, 1'b0, NICKEL, 1'b0, 1'b0, "short for item 3");
        applyPulse(1'b1, 1, 1'b0, NICKEL, 1'b0, 1'b0, "sold out item 1");
        applyPulse(1'b0, 0, 1'b0, NICKEL, 1'b1, 1'b0, "cancel");
        for (int n = 0; n < 200; n++) begin
            r    = $random(seed) & 32'h7fffffff;
            pick = r % 16;
            // mostly coins and selections, pick 15 raises both at once
            applyPulse(pick inside {[7:11], 15}, (r / 16) % NUM_ITEMS, pick < 7 || pick == 15,
                       coinT'(3'((r / 256) % 6)), pick == 14, pick inside {12, 13}, "random");
        end
        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
    parameter int HALF_PERIOD  = 10,   // 20 ns period
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

//--- design/vendingMachine.sv
`timescale 1ns/1ps
`default_nettype none

module vendingMachine import vendPkg::*; #(
    parameter centsT PRICES [NUM_ITEMS] = '{
        9'd100, 9'd0, 9'd125, 9'd175, 9'd225, 9'd250, 9'd100, 9'd325, 9'd375
    },
    parameter centsT       MAX_CREDIT = 9'd500,
    parameter int unsigned SCAN_BITS  = 17
) (
    input  wire                 A1,          // clock
    input  wire                 A2,          // async reset, active high
    input  wire                 selPress,
    input  wire itemIdxT        selItem,
    input  wire                 coinIn,
    input  wire coinT           coinType,
    input  wire                 cancel,
    input  wire                 showRefund,
    output wire [NUM_ITEMS-1:0] availLed,
    output wire [NUM_ITEMS-1:0] soldOutLed,
    output wire [NUM_ITEMS-1:0] dispensedLed,
    output wire [3:0]           anodes,
    output wire segT            segments
);

    centsT   credit;
    centsT   itemPrice;
    dispNumT dispNum;
    logic    dispNeg;
    segT     digit0;
    segT     digit1;
    segT     digit2;
    segT     digit3;

    itemStatus #(
        .PRICES (PRICES)
    ) itemStatusInst (
        .credit     (credit),
        .selItem    (selItem),
        .availLed   (availLed),
        .soldOutLed (soldOutLed),
        .itemPrice  (itemPrice)
    );

    vendController #(
        .MAX_CREDIT (MAX_CREDIT)
    ) vendControllerInst (
        .A1           (A1),
        .A2           (A2),
        .selPress     (selPress),
        .selItem      (selItem),
        .itemPrice    (itemPrice),
        .coinIn       (coinIn),
        .coinType     (coinType),
        .cancel       (cancel),
        .showRefund   (showRefund),
        .credit       (credit),
        .dispensedLed (dispensedLed),
        .dispNum      (dispNum),
        .dispNeg      (dispNeg)
    );

    segmentEncoder segmentEncoderInst (
        .A1      (A1),
        .A2      (A2),
        .dispNum (dispNum),
        .dispNeg (dispNeg),
        .digit0  (digit0),
        .digit1  (digit1),
        .digit2  (digit2),
        .digit3  (digit3)
    );

    displayScanner #(
        .SCAN_BITS (SCAN_BITS)
    ) displayScannerInst (
        .A1       (A1),
        .A2       (A2),
        .digit0   (digit0),
        .digit1   (digit1),
        .digit2   (digit2),
        .digit3   (digit3),
        .anodes   (anodes),
        .segments (segments)
    );

endmodule

`default_nettype wire

//--- design/displayScanner.sv
`timescale 1ns/1ps
`default_nettype none

module displayScanner import vendPkg::*; #(
    parameter int unsigned SCAN_BITS = 17
) (
    input  wire       A1,
    input  wire       A2,
    input  wire segT  digit0,
    input  wire segT  digit1,
    input  wire segT  digit2,
    input  wire segT  digit3,
    output logic [3:0] anodes,
    output segT       segments
);

    logic [SCAN_BITS+1:0] scanCount;   // free running refresh counter
    logic [1:0]           scanSel;

    always_ff @(posedge A1 or posedge A2) begin
        if (A2) begin
            scanCount <= '0;
        end else begin
            scanCount <= scanCount + 1'b1;
        end
    end

    assign scanSel = scanCount[SCAN_BITS+1 -: 2];

    always_comb begin
        case (scanSel)
            2'd0:    begin anodes = 4'b1110; segments = digit0; end
            2'd1:    begin anodes = 4'b1101; segments = digit1; end
            2'd2:    begin anodes = 4'b1011; segments = digit2; end
            default: begin anodes = 4'b0111; segments = digit3; end
        endcase
    end

endmodule

`default_nettype wire

//--- design/segmentEncoder.sv
`timescale 1ns/1ps
`default_nettype none

module segmentEncoder import vendPkg::*; (
    input  wire          A1,
    input  wire          A2,
    input  wire dispNumT dispNum,
    input  wire          dispNeg,
    output segT          digit0,
    output segT          digit1,
    output segT          digit2,
    output segT          digit3
);

    localparam segT POINT_MASK = 8'hFE;   // bit 0 low lights the point

    logic [3:0] ones;
    logic [3:0] tens;
    logic [3:0] hundreds;
    logic [3:0] thousands;

    // decimal digit to its segment code
    function automatic segT segCode(input logic [3:0] value);
        return SEG_DIGIT[value];
    endfunction

    assign ones      = 4'(dispNum % 14'd10);
    assign tens      = 4'((dispNum / 14'd10) % 14'd10);
    assign hundreds  = 4'((dispNum / 14'd100) % 14'd10);
    assign thousands = 4'((dispNum / 14'd1000) % 14'd10);

    always_ff @(posedge A1 or posedge A2) begin
        if (A2) begin
            digit0 <= SEG_DIGIT[0];
            digit1 <= SEG_DIGIT[0];
            digit2 <= SEG_DIGIT[0] & POINT_MASK;   // reads 0.00
            digit3 <= SEG_DIGIT[0];
        end else begin
            digit0 <= segCode(ones);
            digit1 <= segCode(tens);
            digit2 <= segCode(hundreds) & POINT_MASK;   // dollars and cents split
            digit3 <= dispNeg ? SEG_MINUS : segCode(thousands);
        end
    end

endmodule

`default_nettype wire

//--- design/vendController.sv
`timescale 1ns/1ps
`default_nettype none

module vendController import vendPkg::*; #(
    parameter centsT MAX_CREDIT = 9'd500
) (
    input  wire                  A1,
    input  wire                  A2,
    input  wire                  selPress,
    input  wire itemIdxT         selItem,
    input  wire centsT           itemPrice,
    input  wire                  coinIn,
    input  wire coinT            coinType,
    input  wire                  cancel,
    input  wire                  showRefund,
    output centsT                credit,
    output logic [NUM_ITEMS-1:0] dispensedLed,
    output dispNumT              dispNum,
    output logic                 dispNeg
);

    localparam logic [14:0] REFUSED_MAX = 15'd9999;   // display limit

    ctrlStateT   state;
    dispNumT     refused;      // cents of coins turned away
    centsT       coinValue;
    logic [9:0]  coinSum;      // one bit wider than credit
    logic [14:0] refusedSum;
    centsT       changeAmt;
    centsT       shortfall;
    logic        coinFits;
    logic        soldOut;
    logic        canBuy;

    assign coinValue  = COIN_CENTS(coinType);
    assign coinSum    = {1'b0, credit} + {1'b0, coinValue};
    assign coinFits   = (coinSum <= {1'b0, MAX_CREDIT});
    assign refusedSum = {1'b0, refused} + {6'd0, coinValue};

    assign changeAmt = credit - itemPrice;
    assign shortfall = itemPrice - credit;
    assign soldOut   = (itemPrice == '0);
    assign canBuy    = (credit >= itemPrice);

    // pulses are served in order selection, coin, cancel, showRefund
    always_ff @(posedge A1 or posedge A2) begin
        if (A2) begin
            state        <= IDLE;
            credit       <= '0;
            refused      <= '0;
            dispensedLed <= '0;
            dispNum      <= '0;
            dispNeg      <= 1'b0;
        end else if (selPress) begin
            if (state != CREDIT) begin           // no money in, price check
                dispNum <= {5'd0, itemPrice};
                dispNeg <= 1'b0;
            end else if (!soldOut && canBuy) begin
                dispNum      <= {5'd0, changeAmt};
                dispNeg      <= 1'b0;
                credit       <= '0;
                dispensedLed <= {{(NUM_ITEMS-1){1'b0}}, 1'b1} << selItem;
                state        <= VENDED;
            end else if (!soldOut) begin         // show what is still missing
                dispNum <= {5'd0, shortfall};
                dispNeg <= 1'b1;
            end
        end else if (coinIn) begin
            if (coinFits) begin
                credit  <= coinSum[8:0];
                dispNum <= {5'd0, coinSum[8:0]};
                dispNeg <= 1'b0;
                state   <= CREDIT;
            end else begin
                // tally saturates at the largest displayable value
                refused <= (refusedSum > REFUSED_MAX) ? REFUSED_MAX[13:0] : refusedSum[13:0];
            end
        end else if (cancel) begin
            state        <= IDLE;
            credit       <= '0;
            refused      <= '0;
            dispensedLed <= '0;
            dispNum      <= '0;
            dispNeg      <= 1'b0;
        end else if (showRefund) begin
            dispNum <= refused;
            dispNeg <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- design/itemStatus.sv
`timescale 1ns/1ps
`default_nettype none

module itemStatus import vendPkg::*; #(
    parameter centsT PRICES [NUM_ITEMS] = '{
        9'd100, 9'd0, 9'd125, 9'd175, 9'd225, 9'd250, 9'd100, 9'd325, 9'd375
    }
) (
    input  wire centsT             credit,
    input  wire itemIdxT           selItem,
    output logic [NUM_ITEMS-1:0]   availLed,
    output logic [NUM_ITEMS-1:0]   soldOutLed,
    output centsT                  itemPrice
);

    logic selValid;

    // a zero price marks an empty slot
    always_comb begin
        for (int i = 0; i < NUM_ITEMS; i++) begin
            soldOutLed[i] = (PRICES[i] == '0);
            availLed[i]   = !soldOutLed[i] && (credit >= PRICES[i]);
        end
    end

    assign selValid = (selItem < itemIdxT'(NUM_ITEMS));

    // out-of-range selections look like a sold-out item
    assign itemPrice = selValid ? PRICES[selItem] : '0;

endmodule

`default_nettype wire

//--- design/vendPkg.sv
`default_nettype none

package vendPkg;

    typedef logic [8:0]  centsT;    // price, credit and change in cents
    typedef logic [13:0] dispNumT;  // display value, 0 to 9999
    typedef logic [3:0]  itemIdxT;  // item 0 to 8
    typedef logic [7:0]  segT;      // active low, bit 0 is the decimal point

    localparam int NUM_ITEMS = 9;

    typedef enum logic [2:0] {
        NICKEL  = 3'd0,
        DIME    = 3'd1,
        QUARTER = 3'd2,
        FIFTY   = 3'd3,
        DOLLAR  = 3'd4,
        FIVE    = 3'd5
    } coinT;

    typedef enum logic [1:0] {
        IDLE,    // no credit inserted
        CREDIT,  // credit available
        VENDED   // item dispensed, change on display
    } ctrlStateT;

    // codes for 0 to 9, point off
    localparam segT SEG_DIGIT [10] = '{
        8'b10000001, 8'b11110011, 8'b01001001, 8'b01100001, 8'b00110011,
        8'b00100101, 8'b00000101, 8'b11110001, 8'b00000001, 8'b00100001
    };

    localparam segT SEG_MINUS = 8'b01111111;

    function automatic centsT COIN_CENTS(input coinT coin);
        case (coin)
            NICKEL:  return 9'd5;
            DIME:    return 9'd10;
            QUARTER: return 9'd25;
            FIFTY:   return 9'd50;
            DOLLAR:  return 9'd100;
            FIVE:    return 9'd500;
            default: return 9'd0;   // unused encodings carry no value
        endcase
    endfunction

endpackage

`default_nettype wire
